// ==== tests/switch_rx_tests.mem ====
// Kind [63:60]: 1 packet, 2 packet started with the next record, 3 lookup, F end
// Packet: port [59:56], beats [55:52], abort beat [51:48] (F none), source MAC [47:0]
// Lookup: expected port [59:56], expected hit [55:52], unused [51:48], MAC [47:0]
105F0010A4C31E01
112F0010A4C32F02
107F00163EB5C403
30100010A4C31E01
31100010A4C32F02
30000A1B2C3D4E5F
// First address moves from port 0 to port 1
113F0010A4C31E01
31100010A4C31E01
// Both ports at once
204F021B77D00904
116F0050569A3E05
// Abort at beat 1 is not learned, abort at beat 3 is
104100E04C681106
300000E04C681106
116308002711AB07
311008002711AB07
// Fill the table, the ninth address evicts the first
102F3C5AB4E2CD08
113FF0DEF1330A09
104F001B21D46F0A
30000010A4C31E01
31100010A4C32F02
301000163EB5C403
3010021B77D00904
31100050569A3E05
311008002711AB07
30103C5AB4E2CD08
3110F0DEF1330A09
3010001B21D46F0A
F000000000000000

// ==== filelist.f ====
+incdir+source
source/net_stream_pkg.sv
source/mac_table_pkg.sv
source/rx_src_mac.sv
source/learn_arbiter.sv
source/mac_learn_table.sv
source/switch_rx_learn.sv
tests/tb_switch_rx_learn.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_switch_rx_learn
RTL_TOP   := switch_rx_learn
FILELIST  := filelist.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== tests/tb_switch_rx_learn.sv ====
/*
 * Testbench for the switch receive learning path. Reads packets and
 * lookups from the test data file, drives both receive ports, checks
 * the forwarded streams against expected beats and the table answers
 * against the recorded results. Built and run through the Makefile.
 */
`timescale 1ns/100ps
`include "eth_defs.svh"

module tb_switch_rx_learn
	import net_stream_pkg::*;
	import mac_table_pkg::*;
();

	// Record kinds in the data file
	localparam logic [3:0]  KIND_PACKET        = 4'h1;
	localparam logic [3:0]  KIND_PAIR          = 4'h2;
	localparam logic [3:0]  KIND_LOOKUP        = 4'h3;
	localparam logic [3:0]  KIND_END           = 4'hF;
	localparam int          MAX_RECORDS        = 64;
	localparam int          CYCLES_PER_RECORD  = 200;
	localparam int          IDLE_BEFORE_LOOKUP = 12;
	localparam int          DRAIN_CYCLES       = 50;
	localparam logic [31:0] LFSR_SEED          = 32'h601f;
	localparam logic [31:0] LFSR_TAPS          = 32'h80200003;

	logic        clk = 1'b0;
	logic        reset;
	logic        s_valid [2];
	logic        s_ready [2];
	beat_data_t  s_data [2];
	beat_bytes_t s_bytes [2];
	logic        s_last [2];
	logic        s_abort [2];
	logic        m_valid [2];
	logic        m_ready [2];
	beat_data_t  m_data [2];
	beat_bytes_t m_bytes [2];
	logic        m_last [2];
	logic        m_abort [2];
	logic        lkup_valid;
	mac_addr_t   lkup_mac;
	logic        lkup_done;
	logic        lkup_hit;
	port_id_t    lkup_port;

	logic [63:0] records [MAX_RECORDS];
	int          n_records = 0;
	// Expected forward traffic per port as {abort, last, bytes, data}
	logic [35:0] exp_q0 [$];
	logic [35:0] exp_q1 [$];

	switch_rx_learn u_switch_rx_learn (
		.i_clk(clk), .i_reset(reset),
		.i_s0_valid(s_valid[0]), .o_s0_ready(s_ready[0]),
		.i_s0_data(s_data[0]), .i_s0_bytes(s_bytes[0]),
		.i_s0_last(s_last[0]), .i_s0_abort(s_abort[0]),
		.o_m0_valid(m_valid[0]), .i_m0_ready(m_ready[0]),
		.o_m0_data(m_data[0]), .o_m0_bytes(m_bytes[0]),
		.o_m0_last(m_last[0]), .o_m0_abort(m_abort[0]),
		.i_s1_valid(s_valid[1]), .o_s1_ready(s_ready[1]),
		.i_s1_data(s_data[1]), .i_s1_bytes(s_bytes[1]),
		.i_s1_last(s_last[1]), .i_s1_abort(s_abort[1]),
		.o_m1_valid(m_valid[1]), .i_m1_ready(m_ready[1]),
		.o_m1_data(m_data[1]), .o_m1_bytes(m_bytes[1]),
		.o_m1_last(m_last[1]), .o_m1_abort(m_abort[1]),
		.i_lkup_valid(lkup_valid), .i_lkup_mac(lkup_mac),
		.o_lkup_done(lkup_done), .o_lkup_hit(lkup_hit),
		.o_lkup_port(lkup_port)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "Stopped at first error");
	endtask

	// Right-shifting Galois LFSR, one step per bit used
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		lfsr_next = state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
	endfunction

	// Beats 0 and 1 carry the source MAC, the rest a counter pattern
	function automatic beat_data_t beat_word(input mac_addr_t mac, input int k, input int seq);
		logic [7:0] kb;
		logic [7:0] sb;
		kb = 8'(k);
		sb = 8'(seq);
		if (k == 0)
			beat_word = mac[`ETH_MACW-1 -: `ETH_DW];
		else if (k == 1)
			beat_word = {mac[`ETH_MACW-`ETH_DW-1:0], sb, kb};
		else
			beat_word = {sb, kb, ~sb, ~kb};
	endfunction

	task automatic push_expected(input int p, input logic [35:0] item);
		if (p == 0)
			exp_q0.push_back(item);
		else
			exp_q1.push_back(item);
	endtask

	// One beat per handshake, the packet ends early at its abort beat
	task automatic send_packet(input int p, input mac_addr_t mac, input int nbeats,
		input int abort_at, input int seq);
		beat_data_t  w;
		beat_bytes_t nb;
		logic        lst;
		logic        abt;
		for (int k = 0; k < nbeats; k++)
		begin
			w = beat_word(mac, k, seq);
			abt = (k == abort_at);
			lst = (k == nbeats - 1) && !abt;
			nb = lst ? beat_bytes_t'(nbeats) : '0;
			s_valid[p] <= 1'b1;
			s_data[p]  <= w;
			s_bytes[p] <= nb;
			s_last[p]  <= lst;
			s_abort[p] <= abt;
			// Aborted beat is dropped, abort shows only after sent beats
			if (!abt)
				push_expected(p, {1'b0, lst, nb, w});
			else if (k > 0)
				push_expected(p, {1'b1, 35'h0});
			@(posedge clk);
			while (!s_ready[p])
				@(posedge clk);
			if (abt)
				break;
		end
		s_valid[p] <= 1'b0;
		s_last[p]  <= 1'b0;
		s_abort[p] <= 1'b0;
	endtask

	// Table answer is due on the edge after the request is sampled
	task automatic lookup_check(input mac_addr_t mac, input logic want_hit,
		input port_id_t want_port);
		repeat (IDLE_BEFORE_LOOKUP) @(posedge clk);
		lkup_valid <= 1'b1;
		lkup_mac   <= mac;
		@(posedge clk);
		lkup_valid <= 1'b0;
		@(posedge clk);
		assert (lkup_done)
			else report_fail("Lookup answer did not arrive one cycle after the request");
		assert (lkup_hit == want_hit)
			else report_fail($sformatf("Fail o_lkup_hit for MAC %h expected %h got %h",
				mac, want_hit, lkup_hit));
		assert (lkup_port == want_port)
			else report_fail($sformatf("Fail o_lkup_port for MAC %h expected %h got %h",
				mac, want_port, lkup_port));
	endtask

	task automatic check_forward(input int p, input logic valid, input logic ready,
		input beat_data_t data, input beat_bytes_t bytes, input logic last, input logic abort);
		logic [35:0] want;
		int          left;
		left = (p == 0) ? exp_q0.size() : exp_q1.size();
		if ((valid && ready) || abort)
		begin
			assert (left != 0)
				else report_fail($sformatf("Port %0d forwarded more than was sent", p));
			if (p == 0)
				want = exp_q0.pop_front();
			else
				want = exp_q1.pop_front();
			assert (abort == want[35])
				else report_fail($sformatf("Fail o_m%0d_abort expected %h got %h",
					p, want[35], abort));
			if (!abort)
			begin
				assert (data == want[31:0])
					else report_fail($sformatf("Fail o_m%0d_data expected %h got %h",
						p, want[31:0], data));
				assert (bytes == want[33:32])
					else report_fail($sformatf("Fail o_m%0d_bytes expected %h got %h",
						p, want[33:32], bytes));
				assert (last == want[34])
					else report_fail($sformatf("Fail o_m%0d_last expected %h got %h",
						p, want[34], last));
			end
		end
	endtask

	////////////////////////////////////////
	// Checkers and background drivers
	////////////////////////////////////////

	always @(posedge clk)
	begin
		if (!reset)
		begin
			check_forward(0, m_valid[0], m_ready[0], m_data[0], m_bytes[0], m_last[0], m_abort[0]);
			check_forward(1, m_valid[1], m_ready[1], m_data[1], m_bytes[1], m_last[1], m_abort[1]);
		end
	end

	// Random back-pressure on both forward streams
	initial
	begin
		logic [31:0] lfsr;
		lfsr = LFSR_SEED;
		m_ready[0] <= 1'b0;
		m_ready[1] <= 1'b0;
		forever
		begin
			@(posedge clk);
			lfsr = lfsr_next(lfsr);
			m_ready[0] <= lfsr[0];
			lfsr = lfsr_next(lfsr);
			m_ready[1] <= lfsr[0];
		end
	end

	// Budget grows with the number of records
	initial
	begin
		wait (n_records != 0);
		repeat (n_records * CYCLES_PER_RECORD) @(posedge clk);
		$display("Watchdog expired after %0d cycles", n_records * CYCLES_PER_RECORD);
		$display("TESTS FAILED");
		$fatal(1, "Simulation timed out");
	end

	////////////////////////////////////////
	// Record sequencer
	////////////////////////////////////////

	initial
	begin
		logic [63:0] rec;
		logic [63:0] nxt;
		int          idx;
		int          seq;
		int          found;
		reset <= 1'b1;
		lkup_valid <= 1'b0;
		lkup_mac <= '0;
		for (int p = 0; p < 2; p++)
		begin
			s_valid[p] <= 1'b0;
			s_data[p]  <= '0;
			s_bytes[p] <= '0;
			s_last[p]  <= 1'b0;
			s_abort[p] <= 1'b0;
		end
		$readmemh("tests/switch_rx_tests.mem", records);
		found = 0;
		for (int i = 0; i < MAX_RECORDS; i++)
		begin
			if (found == 0 && records[i][63:60] == KIND_END)
				found = i + 1;
		end
		assert (found != 0) else report_fail("Test data file has no end marker");
		n_records = found;

		// Three cycles of reset, then all outputs idle
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		assert (!m_valid[0] && !m_valid[1] && !m_abort[0] && !m_abort[1] && !lkup_done)
			else report_fail("Outputs were not idle after reset");

		idx = 0;
		seq = 0;
		while (idx < n_records - 1)
		begin
			rec = records[idx];
			case (rec[63:60])
				KIND_PACKET:
					send_packet(int'(rec[59:56]), rec[47:0], int'(rec[55:52]),
						int'(rec[51:48]), seq);
				// Both ports start on the same edge
				KIND_PAIR:
				begin
					nxt = records[idx + 1];
					fork
						send_packet(int'(rec[59:56]), rec[47:0], int'(rec[55:52]),
							int'(rec[51:48]), seq);
						send_packet(int'(nxt[59:56]), nxt[47:0], int'(nxt[55:52]),
							int'(nxt[51:48]), seq + 1);
					join
					seq++;
					idx++;
				end
				KIND_LOOKUP:
					lookup_check(rec[47:0], rec[55:52] != 4'h0, port_id_t'(rec[59:56]));
				default:
					report_fail($sformatf("Unknown record kind %h at record %0d",
						rec[63:60], idx));
			endcase
			seq++;
			idx++;
		end

		// Give the forward streams time to empty
		for (int i = 0; i < DRAIN_CYCLES && (exp_q0.size() + exp_q1.size()) != 0; i++)
			@(posedge clk);
		if (exp_q0.size() == 0 && exp_q1.size() == 0)
		begin
			$display("TESTS PASSED");
			$finish;
		end
		else
		begin
			$display("Forward streams never delivered %0d expected beats",
				exp_q0.size() + exp_q1.size());
			$display("TESTS FAILED");
			$fatal(1, "Expected beats left over");
		end
	end

endmodule

// ==== source/switch_rx_learn.sv ====
/*
 * Receive learning path of the two-port switch. Two source MAC
 * extractors share the learning table through the round-robin arbiter.
 */
`timescale 1ns/100ps
`include "eth_defs.svh"

module switch_rx_learn
	import net_stream_pkg::*;
	import mac_table_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_reset,
	// Port 0 receive stream and its forward copy
	input  logic        i_s0_valid,
	output logic        o_s0_ready,
	input  beat_data_t  i_s0_data,
	input  beat_bytes_t i_s0_bytes,
	input  logic        i_s0_last,
	input  logic        i_s0_abort,
	output logic        o_m0_valid,
	input  logic        i_m0_ready,
	output beat_data_t  o_m0_data,
	output beat_bytes_t o_m0_bytes,
	output logic        o_m0_last,
	output logic        o_m0_abort,
	// Port 1 receive stream and its forward copy
	input  logic        i_s1_valid,
	output logic        o_s1_ready,
	input  beat_data_t  i_s1_data,
	input  beat_bytes_t i_s1_bytes,
	input  logic        i_s1_last,
	input  logic        i_s1_abort,
	output logic        o_m1_valid,
	input  logic        i_m1_ready,
	output beat_data_t  o_m1_data,
	output beat_bytes_t o_m1_bytes,
	output logic        o_m1_last,
	output logic        o_m1_abort,
	// Table lookup
	input  logic        i_lkup_valid,
	input  mac_addr_t   i_lkup_mac,
	output logic        o_lkup_done,
	output logic        o_lkup_hit,
	output port_id_t    o_lkup_port
);

	logic [`ETH_NPORTS-1:0] learn_valid;
	logic [`ETH_NPORTS-1:0] learn_ready;
	mac_addr_t              learn_mac0;
	mac_addr_t              learn_mac1;
	logic                   wr_valid;
	logic                   wr_ready;
	mac_addr_t              wr_mac;
	port_id_t               wr_port;

	rx_src_mac u_rx0 (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_s_valid(i_s0_valid), .o_s_ready(o_s0_ready),
		.i_s_data(i_s0_data), .i_s_bytes(i_s0_bytes),
		.i_s_last(i_s0_last), .i_s_abort(i_s0_abort),
		.o_m_valid(o_m0_valid), .i_m_ready(i_m0_ready),
		.o_m_data(o_m0_data), .o_m_bytes(o_m0_bytes),
		.o_m_last(o_m0_last), .o_m_abort(o_m0_abort),
		.o_learn_valid(learn_valid[0]), .i_learn_ready(learn_ready[0]),
		.o_learn_mac(learn_mac0)
	);

	rx_src_mac u_rx1 (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_s_valid(i_s1_valid), .o_s_ready(o_s1_ready),
		.i_s_data(i_s1_data), .i_s_bytes(i_s1_bytes),
		.i_s_last(i_s1_last), .i_s_abort(i_s1_abort),
		.o_m_valid(o_m1_valid), .i_m_ready(i_m1_ready),
		.o_m_data(o_m1_data), .o_m_bytes(o_m1_bytes),
		.o_m_last(o_m1_last), .o_m_abort(o_m1_abort),
		.o_learn_valid(learn_valid[1]), .i_learn_ready(learn_ready[1]),
		.o_learn_mac(learn_mac1)
	);

	// One learn write per cycle at most reaches the table
	learn_arbiter u_arb (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_req_valid(learn_valid), .o_req_ready(learn_ready),
		.i_req_mac0(learn_mac0), .i_req_mac1(learn_mac1),
		.o_wr_valid(wr_valid), .i_wr_ready(wr_ready),
		.o_wr_mac(wr_mac), .o_wr_port(wr_port)
	);

	mac_learn_table u_table (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_wr_valid(wr_valid), .o_wr_ready(wr_ready),
		.i_wr_mac(wr_mac), .i_wr_port(wr_port),
		.i_lkup_valid(i_lkup_valid), .i_lkup_mac(i_lkup_mac),
		.o_lkup_done(o_lkup_done), .o_lkup_hit(o_lkup_hit),
		.o_lkup_port(o_lkup_port)
	);

endmodule

// ==== source/mac_learn_table.sv ====
/*
 * Fully associative source address table. Learns which port each
 * MAC was last seen on and answers lookups one cycle later.
 * New addresses fill slots in round-robin order, oldest evicted first.
 */
`timescale 1ns/100ps
`include "eth_defs.svh"

module mac_learn_table
	import mac_table_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_reset,
	// Learn write from the arbiter
	input  logic      i_wr_valid,
	output logic      o_wr_ready,
	input  mac_addr_t i_wr_mac,
	input  port_id_t  i_wr_port,
	// Lookup request and answer
	input  logic      i_lkup_valid,
	input  mac_addr_t i_lkup_mac,
	output logic      o_lkup_done,
	output logic      o_lkup_hit,
	output port_id_t  o_lkup_port
);

	logic [`MACTBL_DEPTH-1:0] ent_valid;
	mac_addr_t                ent_mac [`MACTBL_DEPTH];
	port_id_t                 ent_port [`MACTBL_DEPTH];
	tbl_index_t               repl_ptr;
	logic                     wr_hit;
	tbl_index_t               wr_idx;
	logic                     lk_hit;
	port_id_t                 lk_port;

	////////////////////////////////////////
	// Parallel compare
	////////////////////////////////////////

	// Write side, find an existing entry for the address
	always_comb
	begin
		wr_hit = 1'b0;
		wr_idx = '0;
		for (int i = 0; i < `MACTBL_DEPTH; i++)
		begin
			if (ent_valid[i] && ent_mac[i] == i_wr_mac)
			begin
				wr_hit = 1'b1;
				wr_idx = tbl_index_t'(i);
			end
		end
	end

	// Lookup side, at most one entry matches so OR the ports
	always_comb
	begin
		lk_hit = 1'b0;
		lk_port = '0;
		for (int i = 0; i < `MACTBL_DEPTH; i++)
		begin
			if (ent_valid[i] && ent_mac[i] == i_lkup_mac)
			begin
				lk_hit = 1'b1;
				lk_port = lk_port | ent_port[i];
			end
		end
	end

	////////////////////////////////////////
	// Table update
	////////////////////////////////////////

	// Always ready once out of reset
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_wr_ready <= 1'b0;
		else
			o_wr_ready <= 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			ent_valid <= '0;
			repl_ptr <= '0;
		end
		else if (i_wr_valid && o_wr_ready && !wr_hit)
		begin
			ent_valid[repl_ptr] <= 1'b1;
			repl_ptr <= repl_ptr + 1'b1;
		end
	end

	// Known address only moves port, new one takes the oldest slot
	always_ff @(posedge i_clk)
	begin
		if (i_wr_valid && o_wr_ready)
		begin
			if (wr_hit)
				ent_port[wr_idx] <= i_wr_port;
			else
			begin
				ent_mac[repl_ptr] <= i_wr_mac;
				ent_port[repl_ptr] <= i_wr_port;
			end
		end
	end

	////////////////////////////////////////
	// Lookup answer
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_lkup_done <= 1'b0;
		else
			o_lkup_done <= i_lkup_valid;
	end

	// Reads the table as it stood before this edge's write
	always_ff @(posedge i_clk)
	begin
		if (i_lkup_valid)
		begin
			o_lkup_hit  <= lk_hit;
			o_lkup_port <= lk_port;
		end
	end

endmodule

// ==== source/learn_arbiter.sv ====
/*
 * Round-robin arbiter between the per-port learn requests.
 * Passes one request at a time to the table write port, tagged
 * with the number of the port it came from.
 */
`timescale 1ns/100ps
`include "eth_defs.svh"

module learn_arbiter
	import mac_table_pkg::*;
(
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic [`ETH_NPORTS-1:0] i_req_valid,
	output logic [`ETH_NPORTS-1:0] o_req_ready,
	input  mac_addr_t              i_req_mac0,
	input  mac_addr_t              i_req_mac1,
	output logic                   o_wr_valid,
	input  logic                   i_wr_ready,
	output mac_addr_t              o_wr_mac,
	output port_id_t               o_wr_port
);

	arb_state_t state;
	port_id_t   prio;
	port_id_t   win;
	port_id_t   idx;
	logic       win_any;
	logic       can_take;
	logic       take;

	// Search from the priority pointer for the first requester
	always_comb
	begin
		win = prio;
		win_any = 1'b0;
		for (int k = 0; k < `ETH_NPORTS; k++)
		begin
			idx = port_id_t'(prio + k);
			if (!win_any && i_req_valid[idx])
			begin
				win = idx;
				win_any = 1'b1;
			end
		end
	end

	// Free to grant when idle or when the held write is leaving
	assign can_take = (state == ARB_IDLE) || i_wr_ready;
	assign take = can_take && win_any;
	assign o_wr_valid = (state == ARB_HOLD);

	always_comb
	begin
		o_req_ready = '0;
		o_req_ready[win] = take;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state <= ARB_IDLE;
			prio <= '0;
		end
		else if (take)
		begin
			state <= ARB_HOLD;
			// Winner drops to lowest priority
			prio <= port_id_t'(win + 1'b1);
		end
		else if (i_wr_ready)
			state <= ARB_IDLE;
	end

	always_ff @(posedge i_clk)
	begin
		if (take)
		begin
			o_wr_mac  <= (win == '0) ? i_req_mac0 : i_req_mac1;
			o_wr_port <= win;
		end
	end

	// Port just served yields to any port still waiting
	a_rr_turn: assert property (@(posedge i_clk) disable iff (i_reset)
		(|o_req_ready) && |(i_req_valid & ~o_req_ready)
		|=> !(|(o_req_ready & $past(o_req_ready))));

	// Write request held with its payload until the table takes it
	a_wr_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		o_wr_valid && !i_wr_ready |=> o_wr_valid && $stable(o_wr_mac) && $stable(o_wr_port));

endmodule

// ==== source/rx_src_mac.sv ====
/*
 * Per-port source MAC extractor. Forwards the packet stream through one
 * register stage and raises a learn request holding the source address
 * taken from beats 0 and 1. One instance sits on every receive port.
 */
`timescale 1ns/100ps
`include "eth_defs.svh"

module rx_src_mac
	import net_stream_pkg::*;
	import mac_table_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_reset,
	// Incoming packet stream
	input  logic        i_s_valid,
	output logic        o_s_ready,
	input  beat_data_t  i_s_data,
	input  beat_bytes_t i_s_bytes,
	input  logic        i_s_last,
	input  logic        i_s_abort,
	// Forwarded packet stream
	output logic        o_m_valid,
	input  logic        i_m_ready,
	output beat_data_t  o_m_data,
	output beat_bytes_t o_m_bytes,
	output logic        o_m_last,
	output logic        o_m_abort,
	// Learn request toward the arbiter
	output logic        o_learn_valid,
	input  logic        i_learn_ready,
	output mac_addr_t   o_learn_mac
);

	logic       s_xfer;
	logic       m_active;
	logic [1:0] posn;
	beat_data_t beat0_q;

	// Stall input if either output is blocked
	assign o_s_ready = (!o_m_valid || i_m_ready) && (!o_learn_valid || i_learn_ready);
	assign s_xfer = i_s_valid && o_s_ready;

	////////////////////////////////////////
	// Source address capture
	////////////////////////////////////////

	// Beat position, sticks at 2 once the address is past
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			posn <= 2'd0;
		else if (s_xfer)
		begin
			if (i_s_last || i_s_abort)
				posn <= 2'd0;
			else if (posn != 2'd2)
				posn <= posn + 2'd1;
		end
	end

	// Beat 0 is the top 32 bits of the address
	always_ff @(posedge i_clk)
	begin
		if (s_xfer && posn == 2'd0)
			beat0_q <= i_s_data;
	end

	// Request goes up the cycle after beat 1, unless that beat aborts
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_learn_valid <= 1'b0;
		else if (s_xfer && posn == 2'd1 && !i_s_abort)
			o_learn_valid <= 1'b1;
		else if (i_learn_ready)
			o_learn_valid <= 1'b0;
	end

	// Low 16 bits of the address sit in the upper half of beat 1
	always_ff @(posedge i_clk)
	begin
		if (s_xfer && posn == 2'd1 && !i_s_abort)
			o_learn_mac <= {beat0_q, i_s_data[`ETH_DW-1 -: (`ETH_MACW - `ETH_DW)]};
	end

	////////////////////////////////////////
	// Forward register stage
	////////////////////////////////////////

	// Aborted beat carries no data downstream
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_m_valid <= 1'b0;
		else if (!o_m_valid || i_m_ready)
			o_m_valid <= s_xfer && !i_s_abort;
	end

	always_ff @(posedge i_clk)
	begin
		if (s_xfer)
		begin
			o_m_data  <= i_s_data;
			o_m_bytes <= i_s_bytes;
			o_m_last  <= i_s_last;
		end
	end

	// Set while the current packet has beats already sent on
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			m_active <= 1'b0;
		else if (s_xfer)
			m_active <= !i_s_last && !i_s_abort;
	end

	// Abort only matters downstream if part of the packet went out
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_m_abort <= 1'b0;
		else if (s_xfer && i_s_abort && m_active)
			o_m_abort <= 1'b1;
		else if (!o_m_valid || i_m_ready)
			o_m_abort <= 1'b0;
	end

	// Arbiter sees a steady address while it holds off
	a_learn_stable: assert property (@(posedge i_clk) disable iff (i_reset)
		o_learn_valid && !i_learn_ready |=> o_learn_valid && $stable(o_learn_mac));

endmodule

// ==== source/mac_table_pkg.sv ====
/*
 * Types for source address learning: addresses, port numbers,
 * table slots and the learn arbiter state.
 */
`include "eth_defs.svh"

package mac_table_pkg;

	// Station address as seen on the wire
	typedef logic [`ETH_MACW-1:0] mac_addr_t;

	// Receive port number
	typedef logic [$clog2(`ETH_NPORTS)-1:0] port_id_t;

	// Slot number inside the learning table
	typedef logic [$clog2(`MACTBL_DEPTH)-1:0] tbl_index_t;

	// Arbiter either waits for a request or holds a pending write
	typedef enum logic {
		ARB_IDLE,
		ARB_HOLD
	} arb_state_t;

endpackage

// ==== source/net_stream_pkg.sv ====
/*
 * Types carried on the per-port packet streams.
 * Import into modules that handle beat data or byte counts.
 */
`include "eth_defs.svh"

package net_stream_pkg;

	// One beat of packet data, first byte in the top lane
	typedef logic [`ETH_DW-1:0] beat_data_t;

	// Valid bytes in the final beat, 0 means the whole word
	typedef logic [$clog2(`ETH_DW/8)-1:0] beat_bytes_t;

endpackage

// ==== source/eth_defs.svh ====
/*
 * Global widths and sizes for the switch receive learning path.
 * Include in any package or module that sizes a port or an array.
 */
`ifndef ETH_DEFS_SVH
`define ETH_DEFS_SVH

// Bits per stream beat, four bytes
`define ETH_DW		32

// Bits in an Ethernet MAC address
`define ETH_MACW	48

// Receive ports feeding the learning table
`define ETH_NPORTS	2

// Entries in the fully associative MAC table
`define MACTBL_DEPTH	8

`endif
